//--- compile.f
+incdir+logic
logic/regTypes.sv
logic/aluTypes.sv
logic/operandBus.sv
logic/arithUnit.sv
logic/pcStackUnit.sv
logic/regBank.sv
logic/execCore.sv
test/execCore_sva.sv
test/execCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the execCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module execCoreTb -f compile.f \
    -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VexecCoreTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- test/execCoreTb.sv
`include "execCore_params.svh"

module execCoreTb;

    logic                   fast_clock;
    logic                   reset;
    logic                   enable;
    regTypes::regIndex      sourceA, sourceB, dest;
    regTypes::bankOp        control;
    aluTypes::aluOp         operation;
    logic                   branch;
    logic [`WORD_WIDTH-1:0] memData;
    logic [`WORD_WIDTH-1:0] currentPc, currentSp, memoryOutput;
    logic                   privileged, zeroFlag;

    // Reference bank, slot 16 is the privileged SP
    logic [`WORD_WIDTH-1:0] refBank [0:16];
    logic                   refPriv, refZero;
    logic                   pendValid, pendBr;
    logic [`WORD_WIDTH-1:0] pendA, pendB, pendPc, pendSp;
    regTypes::regIndex      pendDest;
    regTypes::bankOp        pendCtl;
    aluTypes::aluOp         pendOp;
    logic [15:0]            lfsr = 16'd79;
    string                  testName = "reset";
    int                     cycleCount = 0;

    execCore DUT (.*);

    initial begin
        fast_clock = 1'b0;
        forever #4 fast_clock = ~fast_clock;
    end

    always @(posedge fast_clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= 2000) begin
            $display("Timeout after 2000 cycles, the tests did not finish");
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    // Taps 16, 14, 13, 11
    function automatic logic [`WORD_WIDTH-1:0] randomBits(input int count);
        logic [`WORD_WIDTH-1:0] value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            value = {value[`WORD_WIDTH-2:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic logic [`WORD_WIDTH-1:0] aluExpect(input aluTypes::aluOp op,
            input logic [`WORD_WIDTH-1:0] a, input logic [`WORD_WIDTH-1:0] b);
        case (op)
            aluTypes::aluAdd:        return a + b;
            aluTypes::aluSub:        return a - b;
            aluTypes::aluAnd:        return a & b;
            aluTypes::aluOr:         return a | b;
            aluTypes::aluXor:        return a ^ b;
            aluTypes::aluShiftLeft:  return a << b[4:0];
            aluTypes::aluShiftRight: return a >> b[4:0];
            default:                 return b;
        endcase
    endfunction

    function automatic logic [`WORD_WIDTH-1:0] refRead(input regTypes::regIndex idx);
        if (idx == 4'd14) return refPriv ? refBank[16] : refBank[14];
        return refBank[idx];
    endfunction

    task automatic checkWord(input string what, input logic [`WORD_WIDTH-1:0] expected,
            input logic [`WORD_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s %s expected %h actual %h", testName, what, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic checkFlag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s %s expected %b actual %b", testName, what, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // One clock edge of the model, inputs are the values the DUT sampled
    task automatic modelEdge();
        logic [`WORD_WIDTH-1:0] old [0:16];
        logic [`WORD_WIDTH-1:0] nA, nB, nPc, nSp, result;
        int                     spIdx;
        old = refBank;
        nA  = refRead(sourceA);
        nB  = refRead(sourceB);
        nPc = refBank[15];
        nSp = refRead(4'd14);
        if (pendValid) begin
            result = aluExpect(pendOp, pendA, pendB);
            spIdx  = refPriv ? 16 : 14;
            refBank[15] = pendBr ? result : pendPc + 1;
            case (pendCtl)
                regTypes::opPush: refBank[spIdx] = pendSp - 1;
                regTypes::opPop: refBank[spIdx] = pendSp + 1;
                regTypes::opClearStack: begin
                    refBank[spIdx] = `STACK_TOP;
                    refBank[0]     = `DATA_AREA_START;
                end
                regTypes::opWriteAlu: begin
                    if (pendDest < 4'd14) refBank[pendDest] = result;
                    refZero = (result == '0);
                end
                regTypes::opLoadMemory: if (pendDest < 4'd14) refBank[pendDest] = memData;
                regTypes::opEnterPriv: begin
                    refBank[13] = old[15];
                    refBank[5]  = old[14];
                    refPriv     = 1'b1;
                end
                regTypes::opExitPriv: begin
                    refBank[14] = old[5];
                    refPriv     = 1'b0;
                end
                default: ;
            endcase
        end
        pendValid = enable;
        {pendA, pendB, pendPc, pendSp} = {nA, nB, nPc, nSp};
        pendDest = dest;
        pendCtl  = control;
        pendOp   = operation;
        pendBr   = branch;
    endtask

    task automatic runCycle(input logic en, input regTypes::bankOp ctl,
            input aluTypes::aluOp op, input regTypes::regIndex srcA,
            input regTypes::regIndex srcB, input regTypes::regIndex dst,
            input logic br, input logic [`WORD_WIDTH-1:0] mem);
        @(posedge fast_clock);
        modelEdge();
        enable    <= en;
        control   <= ctl;
        operation <= op;
        sourceA   <= srcA;
        sourceB   <= srcB;
        dest      <= dst;
        branch    <= br;
        memData   <= mem;
        @(negedge fast_clock); // Every cycle is checked against the model
        checkWord("pc", refBank[15], currentPc);
        checkWord("sp", refRead(4'd14), currentSp);
        checkWord("memoryOutput", refRead(dst), memoryOutput);
        checkFlag("privileged", refPriv, privileged);
        checkFlag("zeroFlag", refZero, zeroFlag);
    endtask

    task automatic idle(input regTypes::regIndex dst);
        runCycle(1'b0, regTypes::opNop, aluTypes::aluAdd, 4'd0, 4'd0, dst, 1'b0, memData);
    endtask

    task automatic issue(input regTypes::bankOp ctl, input aluTypes::aluOp op,
            input regTypes::regIndex srcA, input regTypes::regIndex srcB,
            input regTypes::regIndex dst, input logic br);
        runCycle(1'b1, ctl, op, srcA, srcB, dst, br, memData);
    endtask

    task automatic drain(input regTypes::regIndex dst);
        idle(dst);
        idle(dst);
    endtask

    // memData must still hold the value at the commit edge
    task automatic loadReg(input regTypes::regIndex r, input logic [`WORD_WIDTH-1:0] v);
        runCycle(1'b1, regTypes::opLoadMemory, aluTypes::aluPassB, 4'd0, 4'd0, r, 1'b0, v);
        drain(r);
    endtask

    task automatic resetTest();
        testName = "resetTest";
        idle(4'd0);
        checkWord("reg0", `DATA_AREA_START, memoryOutput);
        checkWord("pc", '0, currentPc);
        checkWord("sp", `STACK_TOP, currentSp);
        checkFlag("privileged", 1'b0, privileged);
        checkFlag("zeroFlag", 1'b0, zeroFlag);
    endtask

    task automatic aluTest();
        logic [`WORD_WIDTH-1:0] a, b;
        aluTypes::aluOp         op;
        testName = "aluTest";
        for (int i = 0; i < 9; i++) begin
            op = (i == 8) ? aluTypes::aluSub : aluTypes::aluOp'(i[2:0]);
            a  = randomBits(`WORD_WIDTH);
            b  = (i == 8) ? a : randomBits(`WORD_WIDTH); // Equal sub gives zero
            loadReg(4'd1, a);
            loadReg(4'd2, b);
            issue(regTypes::opWriteAlu, op, 4'd1, 4'd2, 4'd3, 1'b0);
            drain(4'd3);
            checkWord("aluResult", aluExpect(op, a, b), memoryOutput);
            checkFlag("zeroFlag", aluExpect(op, a, b) == '0, zeroFlag);
        end
    endtask

    task automatic backToBackTest();
        logic [`WORD_WIDTH-1:0] x, y;
        testName = "backToBackTest";
        x = randomBits(`WORD_WIDTH);
        y = randomBits(`WORD_WIDTH);
        loadReg(4'd6, y);
        loadReg(4'd1, x);
        issue(regTypes::opWriteAlu, aluTypes::aluPassB, 4'd0, 4'd1, 4'd6, 1'b0);
        issue(regTypes::opWriteAlu, aluTypes::aluPassB, 4'd0, 4'd6, 4'd7, 1'b0);
        issue(regTypes::opWriteAlu, aluTypes::aluPassB, 4'd0, 4'd6, 4'd8, 1'b0);
        drain(4'd7);
        checkWord("oldValue", y, memoryOutput);
        idle(4'd8);
        checkWord("newValue", x, memoryOutput);
    endtask

    task automatic pcTest();
        logic [`WORD_WIDTH-1:0] pcStart, spStart, target;
        testName = "pcTest";
        pcStart = currentPc;
        issue(regTypes::opNop, aluTypes::aluAdd, 4'd0, 4'd0, 4'd0, 1'b0);
        drain(4'd0);
        checkWord("increment", pcStart + 1, currentPc);
        target = randomBits(`WORD_WIDTH);
        loadReg(4'd9, target);
        issue(regTypes::opNop, aluTypes::aluPassB, 4'd0, 4'd9, 4'd0, 1'b1);
        drain(4'd0);
        checkWord("branch", target, currentPc);
        pcStart = currentPc;
        spStart = currentSp;
        issue(regTypes::opWriteAlu, aluTypes::aluPassB, 4'd0, 4'd9, 4'd15, 1'b0);
        issue(regTypes::opWriteAlu, aluTypes::aluPassB, 4'd0, 4'd9, 4'd14, 1'b0);
        drain(4'd0);
        checkWord("pcGuard", pcStart + 1, currentPc); // Back to back, both read the same PC
        checkWord("spGuard", spStart, currentSp);
    endtask

    task automatic stackTest();
        logic [`WORD_WIDTH-1:0] sp, pc;
        testName = "stackTest";
        sp = currentSp;
        issue(regTypes::opPush, aluTypes::aluAdd, 4'd0, 4'd0, 4'd0, 1'b0);
        drain(4'd0);
        checkWord("push", sp - 1, currentSp);
        issue(regTypes::opPop, aluTypes::aluAdd, 4'd0, 4'd0, 4'd0, 1'b0);
        drain(4'd0);
        checkWord("pop", sp, currentSp);
        issue(regTypes::opPush, aluTypes::aluAdd, 4'd0, 4'd0, 4'd0, 1'b0);
        drain(4'd0); // SP away from the top before the clear
        loadReg(4'd0, 32'd5);
        issue(regTypes::opClearStack, aluTypes::aluAdd, 4'd0, 4'd0, 4'd0, 1'b0);
        drain(4'd0);
        checkWord("clearReg0", `DATA_AREA_START, memoryOutput);
        checkWord("clearSp", `STACK_TOP, currentSp);
        issue(regTypes::opPush, aluTypes::aluAdd, 4'd0, 4'd0, 4'd0, 1'b0);
        drain(4'd0);
        checkWord("clearPush", `STACK_TOP - 1, currentSp);
        pc = currentPc;
        issue(regTypes::opEnterPriv, aluTypes::aluAdd, 4'd0, 4'd0, 4'd13, 1'b0);
        drain(4'd13);
        checkWord("linkReg", pc, memoryOutput);
        idle(4'd5);
        checkWord("savedSp", `STACK_TOP - 1, memoryOutput);
        checkWord("privSp", `STACK_TOP, currentSp);
        checkFlag("enterPriv", 1'b1, privileged);
        loadReg(4'd5, 32'h0000_1000);
        issue(regTypes::opExitPriv, aluTypes::aluAdd, 4'd0, 4'd0, 4'd0, 1'b0);
        drain(4'd0);
        checkWord("restoredSp", 32'h0000_1000, currentSp);
        checkFlag("exitPriv", 1'b0, privileged);
    endtask

    initial begin
        reset = 1'b1;
        enable = 1'b0;
        {sourceA, sourceB, dest, branch, memData} = '0;
        control   = regTypes::opNop;
        operation = aluTypes::aluAdd;
        repeat (2) @(posedge fast_clock);
        reset <= 1'b0;
        for (int i = 0; i < 17; i++) refBank[i] = '0;
        refBank[0]  = `DATA_AREA_START;
        refBank[14] = `STACK_TOP;
        refBank[16] = `STACK_TOP;
        {refPriv, refZero, pendValid} = 3'b000;
        resetTest();
        aluTest();
        backToBackTest();
        pcTest();
        stackTest();
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- test/execCore_sva.sv
`include "execCore_params.svh"

module execCore_sva (
    input logic                   fast_clock,
    input logic                   reset,
    input logic                   valid,
    input regTypes::bankOp        control,
    input regTypes::regIndex      dest,
    input logic                   branch,
    input logic [`WORD_WIDTH-1:0] aluResult,
    input logic [`WORD_WIDTH-1:0] nextPc,
    input logic [`WORD_WIDTH-1:0] currentPc,
    input logic                   privileged
);

    resetState: assert property (@(posedge fast_clock) reset |=> (currentPc == '0 && !valid))
        else $error("PC or valid not cleared by reset");

    // Destination 15 never overrides the PC path
    pcGuard: assert property (@(posedge fast_clock) disable iff (reset)
        (valid && control == regTypes::opWriteAlu && dest == 4'd15)
        |=> currentPc == $past(branch ? aluResult : nextPc))
        else $error("ALU write reached the PC");

    modeChange: assert property (@(posedge fast_clock) disable iff (reset)
        $changed(privileged) |-> $past(valid && (control == regTypes::opEnterPriv
                                              || control == regTypes::opExitPriv)))
        else $error("Privileged mode changed outside enter or exit");

endmodule

bind regBank execCore_sva sva (.fast_clock(fast_clock), .reset(reset), .valid(ops.valid),
    .control(ops.control), .dest(ops.dest), .branch(ops.branch),
    .aluResult(results.aluResult), .nextPc(results.nextPc), .currentPc(currentPc),
    .privileged(privileged));

//--- logic/execCore.sv
`include "execCore_params.svh"

module execCore (
    input  logic                   fast_clock,
    input  logic                   reset,
    input  logic                   enable,
    input  regTypes::regIndex      sourceA,
    input  regTypes::regIndex      sourceB,
    input  regTypes::regIndex      dest,
    input  regTypes::bankOp        control,
    input  aluTypes::aluOp         operation,
    input  logic                   branch,
    input  logic [`WORD_WIDTH-1:0] memData,
    output logic [`WORD_WIDTH-1:0] currentPc,
    output logic [`WORD_WIDTH-1:0] currentSp,
    output logic [`WORD_WIDTH-1:0] memoryOutput,
    output logic                   privileged,
    output logic                   zeroFlag
);

    operandBus ops();
    resultBus  results();

    // Storage, read stage and commit
    regBank bankInst (
        .fast_clock   (fast_clock),
        .reset        (reset),
        .enable       (enable),
        .sourceA      (sourceA),
        .sourceB      (sourceB),
        .dest         (dest),
        .control      (control),
        .operation    (operation),
        .branch       (branch),
        .memData      (memData),
        .ops          (ops.bank),
        .results      (results.bank),
        .currentPc    (currentPc),
        .currentSp    (currentSp),
        .memoryOutput (memoryOutput),
        .privileged   (privileged),
        .zeroFlag     (zeroFlag)
    );

    arithUnit arithInst (
        .ops     (ops.consumer),
        .results (results.arith)
    );

    pcStackUnit stackInst (
        .ops     (ops.consumer),
        .results (results.stack)
    );

endmodule

//--- logic/regBank.sv
`include "execCore_params.svh"

module regBank (
    input  logic                   fast_clock,
    input  logic                   reset,
    input  logic                   enable,
    input  regTypes::regIndex      sourceA,
    input  regTypes::regIndex      sourceB,
    input  regTypes::regIndex      dest,
    input  regTypes::bankOp        control,
    input  aluTypes::aluOp         operation,
    input  logic                   branch,
    input  logic [`WORD_WIDTH-1:0] memData,
    operandBus.bank                ops,
    resultBus.bank                 results,
    output logic [`WORD_WIDTH-1:0] currentPc,
    output logic [`WORD_WIDTH-1:0] currentSp,
    output logic [`WORD_WIDTH-1:0] memoryOutput,
    output logic                   privileged,
    output logic                   zeroFlag
);

    logic [`WORD_WIDTH-1:0] bank [0:`REG_SLOTS-1];

    regTypes::slotIndex     spSlot;
    regTypes::slotIndex     slotA;
    regTypes::slotIndex     slotB;
    regTypes::slotIndex     slotOut;
    regTypes::slotIndex     commitSlot;
    logic [`WORD_WIDTH-1:0] readA;
    logic [`WORD_WIDTH-1:0] readB;
    logic                   destWritable;
    logic                   spUpdate;

    assign spSlot = privileged ? `PRIV_SP_SLOT : `SP_ALIAS;

    assign slotA   = {1'b0, sourceA};
    assign slotB   = {1'b0, sourceB};
    assign slotOut = {1'b0, dest};

    // Register 14 aliases the mode-selected SP
    assign readA        = (slotA == `SP_ALIAS) ? bank[spSlot] : bank[slotA];
    assign readB        = (slotB == `SP_ALIAS) ? bank[spSlot] : bank[slotB];
    assign memoryOutput = (slotOut == `SP_ALIAS) ? bank[spSlot] : bank[slotOut];
    assign currentSp    = bank[spSlot];
    assign currentPc    = bank[`PC_INDEX];

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            ops.valid <= 1'b0;
        end else begin
            ops.valid <= enable;
        end
    end

    // Read stage, sees the bank before any commit on the same edge
    always_ff @(posedge fast_clock) begin
        ops.operandA  <= readA;
        ops.operandB  <= readB;
        ops.dest      <= dest;
        ops.control   <= control;
        ops.operation <= operation;
        ops.branch    <= branch;
        ops.currentPc <= currentPc;
        ops.currentSp <= currentSp;
    end

    assign commitSlot   = {1'b0, ops.dest};
    assign destWritable = (commitSlot != `SP_ALIAS) && (commitSlot != `PC_INDEX);
    assign spUpdate     = (ops.control == regTypes::opPush)
                       || (ops.control == regTypes::opPop)
                       || (ops.control == regTypes::opClearStack);

    // Commit stage
    always_ff @(posedge fast_clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_SLOTS; i++) begin
                bank[i] <= '0;
            end
            bank[0]             <= `DATA_AREA_START;
            bank[`SP_ALIAS]     <= `STACK_TOP;
            bank[`PRIV_SP_SLOT] <= `STACK_TOP;
            privileged          <= 1'b0;
            zeroFlag            <= 1'b0;
        end else if (ops.valid) begin
            bank[`PC_INDEX] <= ops.branch ? results.aluResult : results.nextPc;
            if (spUpdate) begin
                bank[spSlot] <= results.nextSp;
            end
            case (ops.control)
                regTypes::opWriteAlu: begin
                    if (destWritable) begin
                        bank[commitSlot] <= results.aluResult;
                    end
                    zeroFlag <= results.flags.zero; // Tracks the last ALU write
                end
                regTypes::opClearStack: begin
                    bank[0] <= `DATA_AREA_START;
                end
                regTypes::opLoadMemory: begin
                    if (destWritable) begin
                        bank[commitSlot] <= memData;
                    end
                end
                regTypes::opEnterPriv: begin
                    bank[`LINK_INDEX]     <= bank[`PC_INDEX]; // Return address
                    bank[`SAVED_SP_INDEX] <= bank[`SP_ALIAS]; // User SP
                    privileged            <= 1'b1;
                end
                regTypes::opExitPriv: begin
                    bank[`SP_ALIAS] <= bank[`SAVED_SP_INDEX];
                    privileged      <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- logic/pcStackUnit.sv
`include "execCore_params.svh"

module pcStackUnit (
    operandBus.consumer ops,
    resultBus.stack     results
);

    localparam logic [`WORD_WIDTH-1:0] stepOne = 1;

    logic [`WORD_WIDTH-1:0] spDown;
    logic [`WORD_WIDTH-1:0] spUp;
    logic [`WORD_WIDTH-1:0] spNext;

    // Sequential successor, the bank picks the ALU result on a branch
    assign results.nextPc = ops.currentPc + stepOne;

    // Stack grows downward from STACK_TOP
    assign spDown = ops.currentSp - stepOne;
    assign spUp   = ops.currentSp + stepOne;

    always_comb begin
        case (ops.control)
            regTypes::opPush: begin
                spNext = spDown;
            end
            regTypes::opPop: begin
                spNext = spUp;
            end
            regTypes::opClearStack: begin
                spNext = `STACK_TOP;
            end
            default: begin
                spNext = ops.currentSp; // Hold
            end
        endcase
    end

    assign results.nextSp = spNext;

endmodule

//--- logic/arithUnit.sv
`include "execCore_params.svh"

module arithUnit (
    operandBus.consumer ops,
    resultBus.arith     results
);

    logic [`WORD_WIDTH:0]   sumWide;  // Carry in top bit
    logic [`WORD_WIDTH:0]   diffWide; // Top bit set means no borrow
    logic [4:0]             shiftAmount;
    logic [`WORD_WIDTH-1:0] result;
    logic                   carry;

    assign sumWide  = {1'b0, ops.operandA} + {1'b0, ops.operandB};
    assign diffWide = {1'b0, ops.operandA} + {1'b0, ~ops.operandB} + {{`WORD_WIDTH{1'b0}}, 1'b1};
    assign shiftAmount = ops.operandB[4:0];

    always_comb begin
        carry = 1'b0;
        case (ops.operation)
            aluTypes::aluAdd: begin
                result = sumWide[`WORD_WIDTH-1:0];
                carry  = sumWide[`WORD_WIDTH];
            end
            aluTypes::aluSub: begin
                result = diffWide[`WORD_WIDTH-1:0];
                carry  = diffWide[`WORD_WIDTH];
            end
            aluTypes::aluAnd: begin
                result = ops.operandA & ops.operandB;
            end
            aluTypes::aluOr: begin
                result = ops.operandA | ops.operandB;
            end
            aluTypes::aluXor: begin
                result = ops.operandA ^ ops.operandB;
            end
            aluTypes::aluShiftLeft: begin
                result = ops.operandA << shiftAmount;
            end
            aluTypes::aluShiftRight: begin
                result = ops.operandA >> shiftAmount;
            end
            aluTypes::aluPassB: begin
                result = ops.operandB; // Also the branch target path
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign results.aluResult   = result;
    assign results.flags.zero  = (result == '0);
    assign results.flags.carry = carry;

endmodule

//--- logic/operandBus.sv
`include "execCore_params.svh"

// Read stage register outputs, valid for one commit
interface operandBus;
    logic [`WORD_WIDTH-1:0] operandA;
    logic [`WORD_WIDTH-1:0] operandB;
    regTypes::regIndex      dest;
    regTypes::bankOp        control;
    aluTypes::aluOp         operation;
    logic                   branch;
    logic [`WORD_WIDTH-1:0] currentPc; // PC at issue
    logic [`WORD_WIDTH-1:0] currentSp; // Mode-selected SP at issue
    logic                   valid;

    modport bank (output operandA, operandB, dest, control, operation, branch,
                  currentPc, currentSp, valid);
    modport consumer (input operandA, operandB, dest, control, operation, branch,
                      currentPc, currentSp, valid);
endinterface

// Commit stage results back to the bank
interface resultBus;
    logic [`WORD_WIDTH-1:0] aluResult;
    aluTypes::aluFlags      flags;
    logic [`WORD_WIDTH-1:0] nextPc;
    logic [`WORD_WIDTH-1:0] nextSp;

    modport arith (output aluResult, flags);
    modport stack (output nextPc, nextSp);
    modport bank (input aluResult, flags, nextPc, nextSp);
endinterface

//--- logic/aluTypes.sv
package aluTypes;

    typedef enum logic [2:0] {
        aluAdd        = 3'd0,
        aluSub        = 3'd1,
        aluAnd        = 3'd2,
        aluOr         = 3'd3,
        aluXor        = 3'd4,
        aluShiftLeft  = 3'd5, // Amount from low 5 bits of B
        aluShiftRight = 3'd6, // Logical
        aluPassB      = 3'd7
    } aluOp;

    // Carry is only meaningful for add and sub
    typedef struct packed {
        logic zero;
        logic carry;
    } aluFlags;

endpackage

//--- logic/regTypes.sv
package regTypes;

    // Architectural register number as seen by an instruction
    typedef logic [3:0] regIndex;

    // Physical storage slot, one extra bit for the privileged SP
    typedef logic [4:0] slotIndex;

    // Bank control, one per instruction
    typedef enum logic [2:0] {
        opNop        = 3'd0,
        opWriteAlu   = 3'd1, // dest <- ALU result
        opClearStack = 3'd2, // SP and register 0 back to defaults
        opLoadMemory = 3'd3, // dest <- memData
        opEnterPriv  = 3'd4, // Save PC and user SP, set mode
        opExitPriv   = 3'd5, // Restore user SP, clear mode
        opPush       = 3'd6,
        opPop        = 3'd7
    } bankOp;

endpackage

//--- logic/execCore_params.svh
`ifndef EXECCORE_PARAMS_SVH
`define EXECCORE_PARAMS_SVH

// Datapath width
`define WORD_WIDTH 32

// Register 0 points here after reset or a stack clear
`define DATA_AREA_START 32'd8192

// Empty stack value for both stack pointers
`define STACK_TOP {`WORD_WIDTH{1'b1}}

// Storage slots, 16 architectural plus the privileged SP
`define REG_SLOTS 17

// Special register numbers, sized as storage slot indices
`define SP_ALIAS 5'd14
`define PC_INDEX 5'd15
`define LINK_INDEX 5'd13
`define SAVED_SP_INDEX 5'd5

// Only reachable through the SP alias in privileged mode
`define PRIV_SP_SLOT 5'd16

`endif
